//--- hdl/cur_buf_defs.svh
// Block geometry macros for the current-block buffer; include wherever the sizes are needed
`ifndef CUR_BUF_DEFS_SVH
`define CUR_BUF_DEFS_SVH

// ----------------------------------------
// Pixel and block geometry
// ----------------------------------------

// Bits per luma pixel
`define CUR_PIXEL_W 8

// Rows per block, also pixels per row
`define CUR_BLOCK_DIM 8

// ----------------------------------------
// Memory fetch and row switch
// ----------------------------------------

`define CUR_WORD_PIXELS 4
`define CUR_LOAD_WORDS 16

// One fewer than the row count
`define CUR_SWITCH_STEPS 7

`endif

//--- hdl/cur_buf_pkg.sv
// Shared types of the current-block buffer; import into any module that uses them
package cur_buf_pkg;

`include "cur_buf_defs.svh"

    // ----------------------------------------
    // Basic words
    // ----------------------------------------

    // One block row, pixel 0 in the low bits
    typedef logic [`CUR_BLOCK_DIM*`CUR_PIXEL_W-1:0] pixel_row_t;

    // One word from the external memory
    typedef logic [`CUR_WORD_PIXELS*`CUR_PIXEL_W-1:0] load_word_t;

    // Word index inside a block
    typedef logic [$clog2(`CUR_LOAD_WORDS)-1:0] load_addr_t;

    // Transition step, 0 to CUR_SWITCH_STEPS-1
    typedef logic [$clog2(`CUR_SWITCH_STEPS)-1:0] switch_step_t;

    // ----------------------------------------
    // Whole block
    // ----------------------------------------

    // Same 512 bits seen as rows by the display side
    // and as fetch words by the store side
    typedef union packed {
        pixel_row_t [`CUR_BLOCK_DIM-1:0]  rows;
        load_word_t [`CUR_LOAD_WORDS-1:0] words;
    } cur_block_t;

endpackage

//--- hdl/block_fetch_ctrl.sv
// Starts the sixteen-word block read on cold boot or next_block and delays the write strobe
`include "cur_buf_defs.svh"

module block_fetch_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    en,
    input  logic                    next_block,
    output logic                    block_start,
    output logic                    read_en,
    output logic                    wr_en,
    output cur_buf_pkg::load_addr_t wr_addr
);

    import cur_buf_pkg::*;

    localparam load_addr_t LAST_ADDR = load_addr_t'(`CUR_LOAD_WORDS - 1);

    // Set by reset, cleared by the first start
    logic       cold_boot;
    load_addr_t fetch_addr;

    // ----------------------------------------
    // Start condition
    // ----------------------------------------

    // Only place where a new block is decided
    assign block_start = en & (next_block | cold_boot);

    // ----------------------------------------
    // Read address and strobe
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            cold_boot  <= 1'b1;
            read_en    <= 1'b0;
            fetch_addr <= '0;
        end else if (block_start) begin
            // A start in the middle of a fetch begins again at word 0
            cold_boot  <= 1'b0;
            read_en    <= 1'b1;
            fetch_addr <= '0;
        end else if (en && read_en) begin
            if (fetch_addr == LAST_ADDR) begin
                read_en <= 1'b0;
            end else begin
                fetch_addr <= fetch_addr + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Write side, one cycle behind the read
    // ----------------------------------------

    // Memory answers one cycle after the read strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= read_en;
        end
    end

    // Address follows the strobe, even with en low
    always_ff @(posedge clk) begin
        wr_addr <= fetch_addr;
    end

endmodule

//--- hdl/pingpong_store.sv
// Ping-pong block store whose two banks take new words only while they are not shown
module pingpong_store (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_en,
    input  cur_buf_pkg::load_addr_t wr_addr,
    input  cur_buf_pkg::load_word_t cur_in,
    input  logic                    show_sel,
    output cur_buf_pkg::cur_block_t bank0,
    output cur_buf_pkg::cur_block_t bank1
);

    // Hidden bank is the inverse of show_sel
    logic load_bank0;
    logic load_bank1;

    assign load_bank0 = wr_en & show_sel;
    assign load_bank1 = wr_en & ~show_sel;

    // ----------------------------------------
    // Bank 0
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            bank0 <= '0;
        end else if (load_bank0) begin
            bank0.words[wr_addr] <= cur_in;
        end
    end

    // ----------------------------------------
    // Bank 1
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            bank1 <= '0;
        end else if (load_bank1) begin
            // Word k lands in bits 32k+31 down to 32k
            bank1.words[wr_addr] <= cur_in;
        end
    end

endmodule

//--- hdl/row_switch.sv
// Row switch that picks the shown bank and moves the output one row per cycle to a new block
`include "cur_buf_defs.svh"

module row_switch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    en,
    input  logic                    block_start,
    input  cur_buf_pkg::cur_block_t bank0,
    input  cur_buf_pkg::cur_block_t bank1,
    output logic                    show_sel,
    output cur_buf_pkg::cur_block_t cur_out
);

    import cur_buf_pkg::*;

    localparam switch_step_t LAST_STEP = switch_step_t'(`CUR_SWITCH_STEPS - 1);

    logic         switching;
    switch_step_t step;

    // Bank that show_sel names, and the one being left
    cur_block_t new_bank;
    cur_block_t old_bank;

    // ----------------------------------------
    // Switch state
    // ----------------------------------------

    // block_start already carries en
    always_ff @(posedge clk) begin
        if (rst) begin
            show_sel  <= 1'b0;
            switching <= 1'b0;
            step      <= '0;
        end else if (block_start) begin
            show_sel  <= ~show_sel;
            switching <= 1'b1;
            step      <= '0;
        end else if (en && switching) begin
            if (step == LAST_STEP) begin
                switching <= 1'b0;
                step      <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Output rows
    // ----------------------------------------

    assign new_bank = show_sel ? bank1 : bank0;
    assign old_bank = show_sel ? bank0 : bank1;

    // During step s rows 0..s are new, the rest old
    always_comb begin
        cur_out = '0;
        if (en) begin
            for (int r = 0; r < `CUR_BLOCK_DIM; r++) begin
                if (!switching || r <= int'(step)) begin
                    cur_out.rows[r] = new_bank.rows[r];
                end else begin
                    cur_out.rows[r] = old_bank.rows[r];
                end
            end
        end
    end

endmodule

//--- hdl/cur_buf_top.sv
// Top level that loads 8x8 blocks from memory words and shows them to the motion search engine
module cur_buf_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    en,
    input  logic                    next_block,
    input  cur_buf_pkg::load_word_t cur_in,
    output logic                    read_en,
    output cur_buf_pkg::cur_block_t cur_out
);

    import cur_buf_pkg::*;

    // Fetch control to store and switch
    logic       block_start;
    logic       wr_en;
    load_addr_t wr_addr;

    // Store and switch
    logic       show_sel;
    cur_block_t bank0;
    cur_block_t bank1;

    // ----------------------------------------
    // Fetch sequencing
    // ----------------------------------------

    block_fetch_ctrl u_fetch (
        .clk         (clk),
        .rst         (rst),
        .en          (en),
        .next_block  (next_block),
        .block_start (block_start),
        .read_en     (read_en),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr)
    );

    // ----------------------------------------
    // Bank storage
    // ----------------------------------------

    pingpong_store u_store (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .cur_in   (cur_in),
        .show_sel (show_sel),
        .bank0    (bank0),
        .bank1    (bank1)
    );

    // ----------------------------------------
    // Display side
    // ----------------------------------------

    row_switch u_switch (
        .clk         (clk),
        .rst         (rst),
        .en          (en),
        .block_start (block_start),
        .bank0       (bank0),
        .bank1       (bank1),
        .show_sel    (show_sel),
        .cur_out     (cur_out)
    );

endmodule

//--- tb/tb_cur_buf.sv
// Self-checking testbench for the current-block buffer; run with tb_cur_buf as the top module
`include "cur_buf_defs.svh"

module tb_cur_buf;

    import cur_buf_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int FETCH_GAP = 24;
    localparam int BLOCK_COUNT = 20;
    // Worst case per random block is a start, the gap, the extra gap and en low
    localparam int BLOCK_CYCLES = 1 + FETCH_GAP + 7 + 4;
    localparam int PLANNED_CYCLES = 5 + 25 + 25 + 4 + BLOCK_COUNT * BLOCK_CYCLES + 31;
    localparam int WATCHDOG_CYCLES = PLANNED_CYCLES + 100;

    logic       clk;
    logic       rst;
    logic       en;
    logic       next_block;
    load_word_t cur_in;
    logic       read_en;
    cur_block_t cur_out;

    // Galois LFSR state
    logic [31:0] lfsr_state = 32'h0ada462c;

    // Memory responder
    logic resp_prev_read;
    int   read_cnt;
    int   read_bursts;

    // Reference model
    logic         m_cold;
    logic         m_read;
    logic         m_wr;
    logic         m_sel;
    logic         m_switching;
    load_addr_t   m_addr;
    load_addr_t   m_wr_addr;
    switch_step_t m_step;
    logic [31:0]  mbank [2][`CUR_LOAD_WORDS];

    string test_name;

    cur_buf_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .next_block (next_block),
        .cur_in     (cur_in),
        .read_en    (read_en),
        .cur_out    (cur_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $fatal(1, "watchdog timeout");
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Taps 32 22 2 1
    function automatic logic lfsr_next_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_next_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [511:0] exp_v,
                               input logic [511:0] act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %s expected %0h actual %0h", name, exp_v, act_v);
            $display("TB FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Word 0 in the low bits, so row r is words 2r and 2r+1
    function automatic logic [511:0] bank_block(input logic b);
        logic [511:0] blk;
        for (int w = 0; w < `CUR_LOAD_WORDS; w++) begin
            blk[32*w +: 32] = mbank[b][w];
        end
        return blk;
    endfunction

    function automatic logic [511:0] expected_out(input logic en_v);
        logic [511:0] new_blk;
        logic [511:0] old_blk;
        logic [511:0] out;
        new_blk = bank_block(m_sel);
        old_blk = bank_block(~m_sel);
        out = '0;
        if (en_v) begin
            for (int r = 0; r < `CUR_BLOCK_DIM; r++) begin
                if (!m_switching || r <= int'(m_step)) begin
                    out[64*r +: 64] = new_blk[64*r +: 64];
                end else begin
                    out[64*r +: 64] = old_blk[64*r +: 64];
                end
            end
        end
        return out;
    endfunction

    task automatic model_reset();
        m_cold = 1'b1;
        m_read = 1'b0;
        m_wr = 1'b0;
        m_sel = 1'b0;
        m_switching = 1'b0;
        m_addr = '0;
        m_wr_addr = '0;
        m_step = '0;
        for (int w = 0; w < `CUR_LOAD_WORDS; w++) begin
            mbank[0][w] = '0;
            mbank[1][w] = '0;
        end
    endtask

    // One clock edge of the model
    task automatic model_edge(input logic en_v, input logic start, input logic [31:0] word);
        logic       nxt_wr;
        load_addr_t nxt_wr_addr;
        if (m_wr) begin
            mbank[~m_sel][m_wr_addr] = word;
        end
        nxt_wr = m_read;
        nxt_wr_addr = m_addr;
        if (start) begin
            m_cold = 1'b0;
            m_read = 1'b1;
            m_addr = '0;
            m_sel = ~m_sel;
            m_switching = 1'b1;
            m_step = '0;
        end else begin
            if (en_v && m_read) begin
                if (m_addr == `CUR_LOAD_WORDS - 1) begin
                    m_read = 1'b0;
                end else begin
                    m_addr = m_addr + 1'b1;
                end
            end
            if (en_v && m_switching) begin
                if (m_step == `CUR_SWITCH_STEPS - 1) begin
                    m_switching = 1'b0;
                    m_step = '0;
                end else begin
                    m_step = m_step + 1'b1;
                end
            end
        end
        m_wr = nxt_wr;
        m_wr_addr = nxt_wr_addr;
    endtask

    // Drive on the falling edge, check mid low phase, then step the model
    task automatic run_cycle(input logic en_v, input logic nb_v);
        logic start;
        @(negedge clk);
        en = en_v;
        next_block = nb_v;
        if (resp_prev_read) begin
            cur_in = rand_bits(32);
        end
        #10;
        check_value({test_name, "/cur_out"}, expected_out(en_v), cur_out);
        check_value({test_name, "/read_en"}, m_read, read_en);
        if (read_en) begin
            read_cnt++;
        end else if (resp_prev_read) begin
            check_value({test_name, "/read_len"}, `CUR_LOAD_WORDS, read_cnt);
            read_bursts++;
        end
        resp_prev_read = read_en;
        start = en_v && (nb_v || m_cold);
        model_edge(en_v, start, cur_in);
        if (start) begin
            read_cnt = 0;
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        logic [511:0] held;
        rst = 1'b1;
        en = 1'b0;
        next_block = 1'b0;
        cur_in = '0;
        resp_prev_read = 1'b0;
        read_cnt = 0;
        read_bursts = 0;
        test_name = "reset";
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            if (i == 1) begin
                rst = 1'b0;
            end
            #10;
            check_value("reset/read_en", 0, read_en);
            check_value("reset/cur_out", 0, cur_out);
        end
        model_reset();
        repeat (3) run_cycle(1'b0, 1'b0);

        // First en-high cycle acts as a start
        test_name = "cold_boot";
        run_cycle(1'b1, 1'b0);
        repeat (FETCH_GAP) run_cycle(1'b1, 1'b0);
        check_value("cold_boot/bank0", bank_block(1'b0), dut0.u_store.bank0);
        check_value("cold_boot/shown", 0, cur_out);

        test_name = "next_block";
        run_cycle(1'b1, 1'b1);
        repeat (FETCH_GAP) run_cycle(1'b1, 1'b0);
        check_value("next_block/shown", bank_block(1'b0), cur_out);

        test_name = "gating";
        held = bank_block(m_sel);
        repeat (3) run_cycle(1'b0, 1'b0);
        run_cycle(1'b1, 1'b0);
        check_value("gating/resume", held, cur_out);

        for (int b = 0; b < BLOCK_COUNT; b++) begin
            test_name = $sformatf("block%0d", b);
            run_cycle(1'b1, 1'b1);
            repeat (FETCH_GAP + rand_bits(3)) run_cycle(1'b1, 1'b0);
            check_value({test_name, "/shown"}, bank_block(m_sel), cur_out);
            if (rand_bits(1)) begin
                repeat (1 + rand_bits(2)) run_cycle(1'b0, 1'b0);
            end
        end

        // Second start lands in the middle of the fetch and the switch
        test_name = "restart";
        run_cycle(1'b1, 1'b1);
        repeat (5) run_cycle(1'b1, 1'b0);
        run_cycle(1'b1, 1'b1);
        repeat (FETCH_GAP) run_cycle(1'b1, 1'b0);
        check_value("restart/shown", bank_block(m_sel), cur_out);

        check_value("read_bursts", BLOCK_COUNT + 3, read_bursts);
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- files.f
+incdir+hdl
hdl/cur_buf_pkg.sv
hdl/block_fetch_ctrl.sv
hdl/pingpong_store.sv
hdl/row_switch.sv
hdl/cur_buf_top.sv
tb/tb_cur_buf.sv

//--- Bender.yml
package:
  name: cur_buf

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cur_buf_pkg.sv
      - hdl/block_fetch_ctrl.sv
      - hdl/pingpong_store.sv
      - hdl/row_switch.sv
      - hdl/cur_buf_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_cur_buf.sv
